//--- verilog/mipsPkg.sv
package mipsPkg;

    // Register file depth used by default
    localparam int RegCount = 32;

    // -------------------------------------------------
    // Instruction word views
    // -------------------------------------------------
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFieldsT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeFieldsT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jTypeFieldsT;

    typedef union packed {
        rTypeFieldsT rType;
        iTypeFieldsT iType;
        jTypeFieldsT jType;
    } instrWordT;

    // -------------------------------------------------
    // Encodings
    // -------------------------------------------------
    typedef enum logic [5:0] {
        OpRType = 6'h00,
        OpJ     = 6'h02,
        OpJal   = 6'h03,
        OpBeq   = 6'h04,
        OpBne   = 6'h05,
        OpAddi  = 6'h08,
        OpAndi  = 6'h0c,
        OpOri   = 6'h0d,
        OpLui   = 6'h0f,
        OpLb    = 6'h20,
        OpLw    = 6'h23,
        OpSb    = 6'h28,
        OpSw    = 6'h2b
    } opcodeT;

    // Funct field of R-type words
    localparam logic [5:0] FunctJr  = 6'h08;
    localparam logic [5:0] FunctAdd = 6'h20;
    localparam logic [5:0] FunctSub = 6'h22;
    localparam logic [5:0] FunctAnd = 6'h24;
    localparam logic [5:0] FunctOr  = 6'h25;
    localparam logic [5:0] FunctSlt = 6'h2a;

    typedef enum logic [5:0] {
        AluNop = 6'd0,
        AluAdd = 6'd1,
        AluSub = 6'd2,
        AluAnd = 6'd3,
        AluOr  = 6'd4,
        AluSlt = 6'd5,
        AluLui = 6'd6
    } aluOpT;

    // Destination select, shared by ctrlBundleT and the pipeline tag
    localparam logic [1:0] RegDstRt = 2'd0;
    localparam logic [1:0] RegDstRd = 2'd1;
    localparam logic [1:0] RegDstRa = 2'd2;

    localparam logic [1:0] ByteWord = 2'd0;
    localparam logic [1:0] ByteByte = 2'd1;

    localparam logic [1:0] MemToRegAlu = 2'd0;
    localparam logic [1:0] MemToRegMem = 2'd1;
    localparam logic [1:0] MemToRegPc  = 2'd2;

    // -------------------------------------------------
    // Bundles
    // -------------------------------------------------
    typedef struct packed {
        aluOpT      aluOp;
        logic       aluSrcImm;
        logic [1:0] regDst;
        logic [1:0] byteSize;
        logic       memWrite;
        logic       memRead;
        logic       regWrite;
        logic [1:0] memToReg;
    } ctrlBundleT;

    typedef enum logic [1:0] {
        JumpNone     = 2'd0,
        JumpDirect   = 2'd1,
        JumpRegister = 2'd2,
        JumpBranch   = 2'd3
    } jumpKindT;

    // Destination facts of the instructions ahead in EX and MEM
    typedef struct packed {
        logic       regWriteIdex;
        logic       memReadIdex;
        logic [1:0] regDstIdex;
        logic [4:0] regRtIdex;
        logic [4:0] regRdIdex;
        logic       regWriteExmem;
        logic [4:0] regDstExmem;
    } pipeTagT;

endpackage

//--- verilog/controlDecoder.sv
`timescale 1ns/10ps

module controlDecoder (
    input  mipsPkg::instrWordT  instr,
    output mipsPkg::ctrlBundleT ctrl,
    output mipsPkg::jumpKindT   jumpKind,
    output logic                zeroExtImm,
    output logic                branchOnEqual
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr.rType.opcode;
    assign funct  = instr.rType.funct;

    // -------------------------------------------------
    // Bundle templates
    // -------------------------------------------------

    // Register-register ALU op, result to rd
    function automatic ctrlBundleT aluRegCtrl(input aluOpT op);
        ctrlBundleT c;
        c          = '0;
        c.aluOp    = op;
        c.regDst   = RegDstRd;
        c.regWrite = 1'b1;
        c.memToReg = MemToRegAlu;
        return c;
    endfunction

    // Immediate ALU op, result to rt
    function automatic ctrlBundleT aluImmCtrl(input aluOpT op);
        ctrlBundleT c;
        c           = '0;
        c.aluOp     = op;
        c.aluSrcImm = 1'b1;
        c.regDst    = RegDstRt;
        c.regWrite  = 1'b1;
        c.memToReg  = MemToRegAlu;
        return c;
    endfunction

    // Loads and stores, address is rs + imm
    function automatic ctrlBundleT memCtrl(input logic isStore, input logic isByte);
        ctrlBundleT c;
        c           = '0;
        c.aluOp     = AluAdd;
        c.aluSrcImm = 1'b1;
        c.regDst    = RegDstRt;
        c.byteSize  = isByte ? ByteByte : ByteWord;
        c.memWrite  = isStore;
        c.memRead   = !isStore;
        c.regWrite  = !isStore;
        c.memToReg  = isStore ? MemToRegAlu : MemToRegMem;
        return c;
    endfunction

    // -------------------------------------------------
    // Opcode and funct decode
    // -------------------------------------------------
    always_comb begin
        ctrl          = '0;
        jumpKind      = JumpNone;
        zeroExtImm    = 1'b0;
        branchOnEqual = 1'b0;

        case (opcode)
            OpRType: begin
                case (funct)
                    FunctAdd: ctrl = aluRegCtrl(AluAdd);
                    FunctSub: ctrl = aluRegCtrl(AluSub);
                    FunctAnd: ctrl = aluRegCtrl(AluAnd);
                    FunctOr:  ctrl = aluRegCtrl(AluOr);
                    FunctSlt: ctrl = aluRegCtrl(AluSlt);
                    // Nothing left to do downstream
                    FunctJr:  jumpKind = JumpRegister;
                    default:  ctrl = '0;
                endcase
            end
            OpLw:   ctrl = memCtrl(1'b0, 1'b0);
            OpLb:   ctrl = memCtrl(1'b0, 1'b1);
            OpSw:   ctrl = memCtrl(1'b1, 1'b0);
            OpSb:   ctrl = memCtrl(1'b1, 1'b1);
            OpAddi: ctrl = aluImmCtrl(AluAdd);
            OpAndi: begin
                ctrl       = aluImmCtrl(AluAnd);
                zeroExtImm = 1'b1;
            end
            OpOri: begin
                ctrl       = aluImmCtrl(AluOr);
                zeroExtImm = 1'b1;
            end
            OpLui:  ctrl = aluImmCtrl(AluLui);
            OpBeq: begin
                jumpKind      = JumpBranch;
                branchOnEqual = 1'b1;
            end
            OpBne:  jumpKind = JumpBranch;
            OpJ:    jumpKind = JumpDirect;
            OpJal: begin
                // Link writes PC+4 into r31
                jumpKind      = JumpDirect;
                ctrl.regDst   = RegDstRa;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = MemToRegPc;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

//--- verilog/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  mipsPkg::instrWordT instr,
    input  mipsPkg::pipeTagT   tag,
    input  mipsPkg::jumpKindT  jumpKind,
    input  logic               fwdSelA,
    input  logic               fwdSelB,
    output logic               stall,
    output logic               pcWrite,
    output logic               ifidWrite
);
    import mipsPkg::*;

    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] destIdex;
    logic       idexHitsRs;
    logic       idexHitsRt;
    logic       exmemHitsRs;
    logic       exmemHitsRt;
    logic       needsOperands;
    logic       loadUse;
    logic       branchStall;

    assign rs = instr.rType.rs;
    assign rt = instr.rType.rt;

    // Destination register of the instruction now in EX
    always_comb begin
        case (tag.regDstIdex)
            RegDstRt: destIdex = tag.regRtIdex;
            RegDstRd: destIdex = tag.regRdIdex;
            RegDstRa: destIdex = 5'd31;
            default:  destIdex = 5'd0;
        endcase
    end

    // -------------------------------------------------
    // Operand matches
    // -------------------------------------------------
    assign idexHitsRs = (destIdex != 5'd0) && (destIdex == rs);
    assign idexHitsRt = (destIdex != 5'd0) && (destIdex == rt);

    // A MEM result already on the forward path needs no wait
    assign exmemHitsRs = (tag.regDstExmem != 5'd0) && (tag.regDstExmem == rs) && !fwdSelA;
    assign exmemHitsRt = (tag.regDstExmem != 5'd0) && (tag.regDstExmem == rt) && !fwdSelB;

    // beq, bne and jr read operands in this stage
    assign needsOperands = (jumpKind == JumpBranch) || (jumpKind == JumpRegister);

    // -------------------------------------------------
    // Stall rules
    // -------------------------------------------------
    assign loadUse = tag.memReadIdex && (idexHitsRs || idexHitsRt);

    assign branchStall = needsOperands &&
                         ((tag.regWriteIdex && (idexHitsRs || idexHitsRt)) ||
                          (tag.regWriteExmem && (exmemHitsRs || exmemHitsRt)));

    assign stall     = loadUse || branchStall;
    assign pcWrite   = !stall;
    assign ifidWrite = !stall;

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/10ps

module registerFile #(
    parameter int regCount = mipsPkg::RegCount
) (
    input  logic        Clock,
    input  logic        rstN,
    input  logic [4:0]  readRegA,
    input  logic [4:0]  readRegB,
    input  logic        writeEnable,
    input  logic [4:0]  writeReg,
    input  logic [31:0] writeData,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB
);

    logic [31:0] regs [regCount];

    // -------------------------------------------------
    // Write port
    // -------------------------------------------------

    // r0 never takes a write, so it stays zero after reset
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeReg != 5'd0)) begin
            regs[writeReg] <= writeData;
        end
    end

    // -------------------------------------------------
    // Read ports
    // -------------------------------------------------

    // No write bypass, same-cycle values come through forwarding
    assign readDataA = regs[readRegA];
    assign readDataB = regs[readRegB];

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/10ps

module decodeStage #(
    parameter int regCount = mipsPkg::RegCount
) (
    input  logic                Clock,
    input  logic                rstN,
    input  mipsPkg::instrWordT  instr,
    input  logic [31:0]         pcPlus4,
    input  mipsPkg::pipeTagT    tag,
    input  logic                fwdSelA,
    input  logic                fwdSelB,
    input  logic [31:0]         fwdData,
    input  logic                wbWrite,
    input  logic [4:0]          wbReg,
    input  logic [31:0]         wbData,
    output mipsPkg::ctrlBundleT ctrlOut,
    output logic [31:0]         readDataA,
    output logic [31:0]         readDataB,
    output logic [31:0]         immValue,
    output logic                redirect,
    output logic [31:0]         redirectTarget,
    output logic                flushIf,
    output logic                pcWrite,
    output logic                ifidWrite
);
    import mipsPkg::*;

    ctrlBundleT  ctrlRaw;
    jumpKindT    jumpKind;
    logic        zeroExtImm;
    logic        branchOnEqual;
    logic        stall;
    logic [31:0] rfDataA;
    logic [31:0] rfDataB;
    logic [31:0] signExtImm;
    logic        operandsEqual;
    logic        wantRedirect;

    controlDecoder u_controlDecoder (
        .instr         (instr),
        .ctrl          (ctrlRaw),
        .jumpKind      (jumpKind),
        .zeroExtImm    (zeroExtImm),
        .branchOnEqual (branchOnEqual)
    );

    hazardUnit u_hazardUnit (
        .instr     (instr),
        .tag       (tag),
        .jumpKind  (jumpKind),
        .fwdSelA   (fwdSelA),
        .fwdSelB   (fwdSelB),
        .stall     (stall),
        .pcWrite   (pcWrite),
        .ifidWrite (ifidWrite)
    );

    registerFile #(
        .regCount (regCount)
    ) u_registerFile (
        .Clock       (Clock),
        .rstN        (rstN),
        .readRegA    (instr.rType.rs),
        .readRegB    (instr.rType.rt),
        .writeEnable (wbWrite),
        .writeReg    (wbReg),
        .writeData   (wbData),
        .readDataA   (rfDataA),
        .readDataB   (rfDataB)
    );

    // -------------------------------------------------
    // Operands and immediate
    // -------------------------------------------------
    assign readDataA = fwdSelA ? fwdData : rfDataA;
    assign readDataB = fwdSelB ? fwdData : rfDataB;

    assign signExtImm = {{16{instr.iType.imm[15]}}, instr.iType.imm};
    // andi and ori take the immediate unsigned
    assign immValue   = zeroExtImm ? {16'd0, instr.iType.imm} : signExtImm;

    // -------------------------------------------------
    // Branch resolution and redirect
    // -------------------------------------------------
    assign operandsEqual = (readDataA == readDataB);

    always_comb begin
        case (jumpKind)
            JumpDirect: begin
                wantRedirect   = 1'b1;
                redirectTarget = {pcPlus4[31:28], instr.jType.target, 2'b00};
            end
            JumpRegister: begin
                wantRedirect   = 1'b1;
                redirectTarget = readDataA;
            end
            JumpBranch: begin
                // beq on equal, bne on not equal
                wantRedirect   = (operandsEqual == branchOnEqual);
                redirectTarget = pcPlus4 + {signExtImm[29:0], 2'b00};
            end
            default: begin
                wantRedirect   = 1'b0;
                redirectTarget = pcPlus4;
            end
        endcase
    end

    // A stalled instruction becomes a bubble and fetch holds
    assign ctrlOut  = stall ? '0 : ctrlRaw;
    assign redirect = wantRedirect && !stall;
    assign flushIf  = redirect;

endmodule

//--- verif/decodeStage_chk.sv
`timescale 1ns/10ps

module decodeStageChk (
    input logic                Clock,
    input logic                rstN,
    input logic                stall,
    input mipsPkg::ctrlBundleT ctrlOut,
    input logic                redirect,
    input logic                flushIf,
    input logic                pcWrite,
    input logic                ifidWrite
);

    // Number of assertion failures so far
    int failCount = 0;

    // Both fetch hold lines move together
    holdLinesAgree: assert property (
        @(posedge Clock) disable iff (!rstN) pcWrite == ifidWrite
    ) else begin
        failCount++;
        $error("pcWrite and ifidWrite disagree");
    end

    // A stalled instruction leaves as a bubble
    stallGivesBubble: assert property (
        @(posedge Clock) disable iff (!rstN) stall |-> ((ctrlOut == '0) && !redirect)
    ) else begin
        failCount++;
        $error("stall with nonzero control bundle or active redirect");
    end

    // Fetch flush only on a taken redirect
    flushFollowsRedirect: assert property (
        @(posedge Clock) disable iff (!rstN) flushIf == redirect
    ) else begin
        failCount++;
        $error("flushIf differs from redirect");
    end

endmodule

//--- verif/decodeChecker.sv
`timescale 1ns/10ps

module decodeChecker #(
    parameter int regCount = mipsPkg::RegCount
) (
    input  logic                Clock,
    input  logic                rstN,
    input  mipsPkg::instrWordT  instr,
    input  logic [31:0]         pcPlus4,
    input  mipsPkg::pipeTagT    tag,
    input  logic                fwdSelA,
    input  logic                fwdSelB,
    input  logic [31:0]         fwdData,
    input  logic                wbWrite,
    input  logic [4:0]          wbReg,
    input  logic [31:0]         wbData,
    input  mipsPkg::ctrlBundleT ctrlOut,
    input  logic [31:0]         readDataA,
    input  logic [31:0]         readDataB,
    input  logic [31:0]         immValue,
    input  logic                redirect,
    input  logic [31:0]         redirectTarget,
    input  logic                flushIf,
    input  logic                pcWrite,
    input  logic                ifidWrite,
    output int                  errorCount,
    output int                  checkCount
);
    import mipsPkg::*;

    typedef struct packed {
        ctrlBundleT  ctrl;
        logic [31:0] readA;
        logic [31:0] readB;
        logic [31:0] imm;
        logic        redirect;
        logic        hasTarget;
        logic [31:0] target;
        logic        flush;
        logic        pcWrite;
        logic        ifidWrite;
    } expectT;

    logic [31:0] shadowRegs [regCount];
    logic        armed = 1'b0;
    int          errors = 0;
    int          checks = 0;
    expectT      exp;

    assign errorCount = errors;
    assign checkCount = checks;

    // -------------------------------------------------
    // Shadow register model
    // -------------------------------------------------
    always @(posedge Clock) begin
        armed <= 1'b1;
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                shadowRegs[i] <= '0;
            end
        end else if (wbWrite && (wbReg != 5'd0)) begin
            shadowRegs[wbReg] <= wbData;
        end
    end

    // -------------------------------------------------
    // Reference model
    // -------------------------------------------------
    function automatic expectT expectedOutputs(input instrWordT ins, input pipeTagT t,
                                               input logic selA, input logic selB,
                                               input logic [31:0] fwd, input logic [31:0] pc);
        expectT      e;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [31:0] sext;
        logic        isJr;
        logic        isJump;
        logic        isBranch;
        logic        idexHit;
        logic        exmemHit;
        logic        stall;
        logic        taken;
        e        = '0;
        op       = ins.rType.opcode;
        fn       = ins.rType.funct;
        rs       = ins.rType.rs;
        rt       = ins.rType.rt;
        isJr     = (op == OpRType) && (fn == FunctJr);
        isJump   = (op == OpJ) || (op == OpJal);
        isBranch = (op == OpBeq) || (op == OpBne);

        if (op == OpRType) begin
            e.ctrl.regDst   = RegDstRd;
            e.ctrl.regWrite = 1'b1;
            case (fn)
                FunctAdd: e.ctrl.aluOp = AluAdd;
                FunctSub: e.ctrl.aluOp = AluSub;
                FunctAnd: e.ctrl.aluOp = AluAnd;
                FunctOr:  e.ctrl.aluOp = AluOr;
                FunctSlt: e.ctrl.aluOp = AluSlt;
                default:  e.ctrl = '0;
            endcase
        end else begin
            case (op)
                OpLw, OpLb, OpSw, OpSb: begin
                    e.ctrl.aluOp     = AluAdd;
                    e.ctrl.aluSrcImm = 1'b1;
                    e.ctrl.byteSize  = ((op == OpLb) || (op == OpSb)) ? ByteByte : ByteWord;
                    e.ctrl.memRead   = (op == OpLw) || (op == OpLb);
                    e.ctrl.memWrite  = !e.ctrl.memRead;
                    e.ctrl.regWrite  = e.ctrl.memRead;
                    e.ctrl.memToReg  = e.ctrl.memRead ? MemToRegMem : MemToRegAlu;
                end
                OpAddi, OpAndi, OpOri, OpLui: begin
                    e.ctrl.aluSrcImm = 1'b1;
                    e.ctrl.regWrite  = 1'b1;
                    e.ctrl.aluOp     = (op == OpAddi) ? AluAdd :
                                       (op == OpAndi) ? AluAnd :
                                       (op == OpOri)  ? AluOr  : AluLui;
                end
                OpJal: begin
                    e.ctrl.regDst   = RegDstRa;
                    e.ctrl.regWrite = 1'b1;
                    e.ctrl.memToReg = MemToRegPc;
                end
                default: e.ctrl = '0;
            endcase
        end

        sext    = {{16{ins.iType.imm[15]}}, ins.iType.imm};
        e.imm   = ((op == OpAndi) || (op == OpOri)) ? {16'd0, ins.iType.imm} : sext;
        e.readA = selA ? fwd : shadowRegs[rs];
        e.readB = selB ? fwd : shadowRegs[rt];

        // Destination of the EX instruction
        case (t.regDstIdex)
            2'd0:    dest = t.regRtIdex;
            2'd1:    dest = t.regRdIdex;
            default: dest = 5'd31;
        endcase
        idexHit  = (dest != 5'd0) && ((dest == rs) || (dest == rt));
        exmemHit = t.regWriteExmem && (t.regDstExmem != 5'd0) &&
                   (((t.regDstExmem == rs) && !selA) || ((t.regDstExmem == rt) && !selB));
        stall    = (t.memReadIdex && idexHit) ||
                   ((isBranch || isJr) && ((t.regWriteIdex && idexHit) || exmemHit));

        if (stall) begin
            e.ctrl = '0;
        end
        e.pcWrite   = !stall;
        e.ifidWrite = !stall;

        taken = isJump || isJr ||
                ((op == OpBeq) && (e.readA == e.readB)) ||
                ((op == OpBne) && (e.readA != e.readB));
        e.redirect  = taken && !stall;
        e.flush     = e.redirect;
        e.hasTarget = isJump || isJr || isBranch;
        e.target    = isJump ? {pc[31:28], ins.jType.target, 2'b00} :
                      isJr   ? e.readA : pc + (sext << 2);
        return e;
    endfunction

    task automatic compareField(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // -------------------------------------------------
    // Compare on the falling edge, inputs are stable
    // -------------------------------------------------
    always @(negedge Clock) begin
        if (armed) begin
            exp = expectedOutputs(instr, tag, fwdSelA, fwdSelB, fwdData, pcPlus4);
            checks++;
            compareField("ctrlOut", {16'd0, exp.ctrl}, {16'd0, ctrlOut});
            compareField("readDataA", exp.readA, readDataA);
            compareField("readDataB", exp.readB, readDataB);
            compareField("immValue", exp.imm, immValue);
            compareField("redirect", {31'd0, exp.redirect}, {31'd0, redirect});
            compareField("flushIf", {31'd0, exp.flush}, {31'd0, flushIf});
            compareField("pcWrite", {31'd0, exp.pcWrite}, {31'd0, pcWrite});
            compareField("ifidWrite", {31'd0, exp.ifidWrite}, {31'd0, ifidWrite});
            if (exp.hasTarget) begin
                compareField("redirectTarget", exp.target, redirectTarget);
            end
        end
    end

endmodule

//--- verif/tbDecode.sv
`timescale 1ns/10ps

module tbDecode;
    import mipsPkg::*;

    localparam int regCount    = RegCount;
    localparam int ClockPeriod = 20;
    localparam int ResetCycles = 16;
    localparam int StimCycles  = 2000;
    localparam int Seed        = 32'h2f71_6fce;

    logic        Clock   = 1'b0;
    logic        rstN    = 1'b0;
    instrWordT   instr   = '0;
    logic [31:0] pcPlus4 = '0;
    pipeTagT     tag     = '0;
    logic        fwdSelA = 1'b0;
    logic        fwdSelB = 1'b0;
    logic [31:0] fwdData = '0;
    logic        wbWrite = 1'b0;
    logic [4:0]  wbReg   = '0;
    logic [31:0] wbData  = '0;

    ctrlBundleT  ctrlOut;
    logic [31:0] readDataA;
    logic [31:0] readDataB;
    logic [31:0] immValue;
    logic        redirect;
    logic [31:0] redirectTarget;
    logic        flushIf;
    logic        pcWrite;
    logic        ifidWrite;
    int          errorCount;
    int          checkCount;
    int          cycleCount = 0;
    int          stimCount = 0;

    always #(ClockPeriod / 2) Clock = ~Clock;

    decodeStage #(.regCount(regCount)) u_decodeStage (.*);

    decodeChecker #(.regCount(regCount)) u_decodeChecker (.*);

    bind decodeStage decodeStageChk u_decodeStageChk (
        .Clock     (Clock),
        .rstN      (rstN),
        .stall     (stall),
        .ctrlOut   (ctrlOut),
        .redirect  (redirect),
        .flushIf   (flushIf),
        .pcWrite   (pcWrite),
        .ifidWrite (ifidWrite)
    );

    // -------------------------------------------------
    // Random stimulus
    // -------------------------------------------------

    // Mostly r0..r7 plus r31, so hazards come often
    function automatic logic [4:0] pickReg();
        int unsigned r;
        r = $urandom % 9;
        return (r == 8) ? 5'd31 : r[4:0];
    endfunction

    function automatic instrWordT randomInstr();
        instrWordT   w;
        logic [31:0] raw;
        int unsigned pick;
        raw        = $urandom;
        pick       = $urandom % 20;
        w          = raw;
        w.rType.rs = pickReg();
        w.rType.rt = pickReg();
        if (pick < 6) begin
            w.rType.opcode = OpRType;
            w.rType.rd     = pickReg();
            w.rType.shamt  = 5'd0;
            case (pick)
                0:       w.rType.funct = FunctAdd;
                1:       w.rType.funct = FunctSub;
                2:       w.rType.funct = FunctAnd;
                3:       w.rType.funct = FunctOr;
                4:       w.rType.funct = FunctSlt;
                default: w.rType.funct = FunctJr;
            endcase
        end else begin
            case (pick)
                6:  w.rType.opcode = OpLw;
                7:  w.rType.opcode = OpSw;
                8:  w.rType.opcode = OpLb;
                9:  w.rType.opcode = OpSb;
                10: w.rType.opcode = OpAddi;
                11: w.rType.opcode = OpAndi;
                12: w.rType.opcode = OpOri;
                13: w.rType.opcode = OpLui;
                14: w.rType.opcode = OpBeq;
                15: w.rType.opcode = OpBne;
                16: w.rType.opcode = OpJ;
                17: w.rType.opcode = OpJal;
                // R-type with whatever funct came up
                18: w.rType.opcode = OpRType;
                default: ;
            endcase
        end
        return w;
    endfunction

    task automatic driveRandom();
        pipeTagT t;
        t.regWriteIdex  = ($urandom % 2) == 0;
        t.memReadIdex   = ($urandom % 4) == 0;
        t.regDstIdex    = 2'($urandom % 3);
        t.regRtIdex     = pickReg();
        t.regRdIdex     = pickReg();
        t.regWriteExmem = ($urandom % 2) == 0;
        t.regDstExmem   = pickReg();
        instr   <= randomInstr();
        tag     <= t;
        fwdSelA <= ($urandom % 4) == 0;
        fwdSelB <= ($urandom % 4) == 0;
        fwdData <= $urandom;
        pcPlus4 <= $urandom & 32'hffff_fffc;
        wbWrite <= ($urandom % 2) == 0;
        wbReg   <= pickReg();
        wbData  <= $urandom;
    endtask

    // Zero instruction through reset, then one random word per cycle
    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if ((cycleCount >= ResetCycles - 1) && (stimCount < StimCycles)) begin
            rstN <= 1'b1;
            driveRandom();
            stimCount <= stimCount + 1;
        end
    end

    // -------------------------------------------------
    // Run control
    // -------------------------------------------------
    initial begin
        void'($urandom(Seed));
        wait (stimCount == StimCycles);
        @(posedge Clock);
        @(posedge Clock);
        $display("Decode checks run: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, u_decodeStage.u_decodeStageChk.failCount);
        if ((errorCount == 0) && (u_decodeStage.u_decodeStageChk.failCount == 0) &&
            (checkCount > 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(ClockPeriod * (ResetCycles + StimCycles + 100));
        $display("Timeout: the run did not reach its end in the expected time");
        $display("Test failures found");
        $finish;
    end

endmodule

//--- compile.f
verilog/mipsPkg.sv
verilog/controlDecoder.sv
verilog/hazardUnit.sv
verilog/registerFile.sv
verilog/decodeStage.sv
verif/decodeStage_chk.sv
verif/decodeChecker.sv
verif/tbDecode.sv

//--- run.sh
#!/bin/sh
# Build the decode stage testbench, run it, and look for the pass line

verilator --binary --assert --top-module tbDecode -f compile.f -o simDecode || exit 1

simOut="$(./obj_dir/simDecode +verilator+error+limit+10000)"
echo "$simOut"

echo "$simOut" | grep -qx "All tests passed!" && echo "RESULT: PASS" || {
    echo "RESULT: FAIL"
    exit 1
}
